// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// R-type view of an instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// I-type view, shared by lw, sw and addi
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	// both views overlay the same 32 bits, so opcode, rs and rt line up
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

	// opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;
	localparam logic [5:0] OP_ADDI  = 6'b001000;

	// funct values of the supported R-type ops
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;

	// ALUOp from the main decoder
	// 00 forces an add for address and immediate arithmetic
	localparam logic [1:0] ALUOP_ADD   = 2'b00;
	localparam logic [1:0] ALUOP_FUNCT = 2'b10;

	// operation codes seen by the ALU
	localparam logic [3:0] ALU_AND = 4'b0000;
	localparam logic [3:0] ALU_OR  = 4'b0001;
	localparam logic [3:0] ALU_ADD = 4'b0010;
	localparam logic [3:0] ALU_SUB = 4'b0110;
	localparam logic [3:0] ALU_SLT = 4'b0111;
	localparam logic [3:0] ALU_NOR = 4'b1100;

endpackage

`default_nettype wire

// ==== decode/control_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
	input  logic [5:0] opcode,
	output logic       reg_write,
	output logic       mem_to_reg,
	output logic       mem_read,
	output logic       mem_write,
	output logic       alu_src,
	output logic       reg_dst,
	output logic [1:0] alu_op
);
	import mips_pkg::*;

	always_comb begin
		// unknown opcodes fall through as a bubble
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		alu_src    = 1'b0;
		reg_dst    = 1'b0;
		alu_op     = ALUOP_ADD;

		case (opcode)
			OP_RTYPE: begin
				reg_write = 1'b1;
				reg_dst   = 1'b1;
				alu_op    = ALUOP_FUNCT;
			end
			OP_LW: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
				mem_read   = 1'b1;
				alu_src    = 1'b1;
				alu_op     = ALUOP_ADD;
			end
			OP_SW: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
				alu_op    = ALUOP_ADD;
			end
			OP_ADDI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
				alu_op    = ALUOP_ADD;
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);

	// register zero has no storage
	logic [31:0] regs [31:1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end
		else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// no bypass, a write shows up only after the edge that performs it
	always_comb begin
		if (rs_addr == 5'd0) begin
			rs_data = 32'd0;
		end
		else begin
			rs_data = regs[rs_addr];
		end

		if (rt_addr == 5'd0) begin
			rt_data = 32'd0;
		end
		else begin
			rt_data = regs[rt_addr];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
	input  logic        clk,
	input  logic        rst,
	input  logic        hold,
	input  logic [1:0]  wb_in,
	input  logic [1:0]  m_in,
	input  logic [3:0]  ex_in,
	input  logic [31:0] rs_data_in,
	input  logic [31:0] rt_data_in,
	input  logic [31:0] imm_ext_in,
	input  logic [4:0]  rt_in,
	input  logic [4:0]  rd_in,
	input  logic [5:0]  funct_in,
	output logic        reg_write,
	output logic        mem_to_reg,
	output logic        mem_read,
	output logic        mem_write,
	output logic        alu_src,
	output logic        reg_dst,
	output logic [1:0]  alu_op,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	output logic [31:0] imm_ext,
	output logic [4:0]  rt,
	output logic [4:0]  rd,
	output logic [5:0]  funct
);

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_write  <= 1'b0;
			mem_to_reg <= 1'b0;
			mem_read   <= 1'b0;
			mem_write  <= 1'b0;
			alu_src    <= 1'b0;
			reg_dst    <= 1'b0;
			alu_op     <= 2'b00;
			rs_data    <= 32'd0;
			rt_data    <= 32'd0;
			imm_ext    <= 32'd0;
			rt         <= 5'd0;
			rd         <= 5'd0;
			funct      <= 6'd0;
		end
		else if (!hold) begin
			// wb is {reg_write, mem_to_reg}, m is {mem_read, mem_write}
			reg_write  <= wb_in[1];
			mem_to_reg <= wb_in[0];
			mem_read   <= m_in[1];
			mem_write  <= m_in[0];

			// ex is {reg_dst, alu_op, alu_src}
			alu_src    <= ex_in[0];
			alu_op     <= ex_in[2:1];
			reg_dst    <= ex_in[3];

			rs_data    <= rs_data_in;
			rt_data    <= rt_data_in;
			imm_ext    <= imm_ext_in;
			rt         <= rt_in;
			rd         <= rd_in;
			funct      <= funct_in;
		end
	end

endmodule

`default_nettype wire

// ==== execute/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [3:0]  alu_ctrl,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] result,
	output logic        zero
);
	import mips_pkg::*;

	always_comb begin
		case (alu_ctrl)
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_SLT: begin
				// signed compare, the result is 0 or 1
				result = {31'd0, $signed(a) < $signed(b)};
			end
			ALU_NOR: begin
				result = ~(a | b);
			end
			default: begin
				result = 32'd0;
			end
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== execute/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic [1:0]  alu_op,
	input  logic [5:0]  funct,
	input  logic        alu_src,
	input  logic        reg_dst,
	input  logic [31:0] rs_data,
	input  logic [31:0] rt_data,
	input  logic [31:0] imm_ext,
	input  logic [4:0]  rt,
	input  logic [4:0]  rd,
	output logic [31:0] alu_result,
	output logic        zero,
	output logic [4:0]  dest_reg
);
	import mips_pkg::*;

	logic [3:0]  alu_ctrl;
	logic [31:0] operand_b;

	// ALU control from ALUOp and funct
	always_comb begin
		alu_ctrl = ALU_ADD;
		if (alu_op == ALUOP_FUNCT) begin
			case (funct)
				FN_ADD: alu_ctrl = ALU_ADD;
				FN_SUB: alu_ctrl = ALU_SUB;
				FN_AND: alu_ctrl = ALU_AND;
				FN_OR: alu_ctrl = ALU_OR;
				FN_SLT: alu_ctrl = ALU_SLT;
				FN_NOR: alu_ctrl = ALU_NOR;
				default: alu_ctrl = ALU_ADD;
			endcase
		end
	end

	// immediates feed the second operand for lw, sw and addi
	assign operand_b = alu_src ? imm_ext : rt_data;

	// R-type writes rd, I-type writes rt
	assign dest_reg = reg_dst ? rd : rt;

	alu i_alu (
		.alu_ctrl (alu_ctrl),
		.a        (rs_data),
		.b        (operand_b),
		.result   (alu_result),
		.zero     (zero)
	);

endmodule

`default_nettype wire

// ==== verilog/id_ex_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_core (
	input  logic            clk,
	input  logic            rst,
	input  logic            hold,
	input  mips_pkg::instr_u instr,
	input  logic            wr_en,
	input  logic [4:0]      wr_addr,
	input  logic [31:0]     wr_data,
	output logic [31:0]     alu_result,
	output logic [31:0]     store_data,
	output logic            zero,
	output logic [4:0]      dest_reg,
	output logic            reg_write,
	output logic            mem_to_reg,
	output logic            mem_read,
	output logic            mem_write
);

	logic        dec_reg_write;
	logic        dec_mem_to_reg;
	logic        dec_mem_read;
	logic        dec_mem_write;
	logic        dec_alu_src;
	logic        dec_reg_dst;
	logic [1:0]  dec_alu_op;
	logic [1:0]  wb_ctrl;
	logic [1:0]  m_ctrl;
	logic [3:0]  ex_ctrl;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm_ext;

	logic        ex_alu_src;
	logic        ex_reg_dst;
	logic [1:0]  ex_alu_op;
	logic [31:0] ex_rs_data;
	logic [31:0] ex_rt_data;
	logic [31:0] ex_imm_ext;
	logic [4:0]  ex_rt;
	logic [4:0]  ex_rd;
	logic [5:0]  ex_funct;

	control_decoder i_control_decoder (
		.opcode     (instr.r.opcode),
		.reg_write  (dec_reg_write),
		.mem_to_reg (dec_mem_to_reg),
		.mem_read   (dec_mem_read),
		.mem_write  (dec_mem_write),
		.alu_src    (dec_alu_src),
		.reg_dst    (dec_reg_dst),
		.alu_op     (dec_alu_op)
	);

	assign wb_ctrl = {dec_reg_write, dec_mem_to_reg};
	assign m_ctrl  = {dec_mem_read, dec_mem_write};
	assign ex_ctrl = {dec_reg_dst, dec_alu_op, dec_alu_src};

	reg_file i_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rs_addr (instr.r.rs),
		.rt_addr (instr.r.rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};

	id_ex_reg i_id_ex_reg (
		.clk        (clk),
		.rst        (rst),
		.hold       (hold),
		.wb_in      (wb_ctrl),
		.m_in       (m_ctrl),
		.ex_in      (ex_ctrl),
		.rs_data_in (rs_data),
		.rt_data_in (rt_data),
		.imm_ext_in (imm_ext),
		.rt_in      (instr.r.rt),
		.rd_in      (instr.r.rd),
		.funct_in   (instr.r.funct),
		.reg_write  (reg_write),
		.mem_to_reg (mem_to_reg),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.alu_src    (ex_alu_src),
		.reg_dst    (ex_reg_dst),
		.alu_op     (ex_alu_op),
		.rs_data    (ex_rs_data),
		.rt_data    (ex_rt_data),
		.imm_ext    (ex_imm_ext),
		.rt         (ex_rt),
		.rd         (ex_rd),
		.funct      (ex_funct)
	);

	// sw stores the registered rt value
	assign store_data = ex_rt_data;

	ex_stage i_ex_stage (
		.alu_op     (ex_alu_op),
		.funct      (ex_funct),
		.alu_src    (ex_alu_src),
		.reg_dst    (ex_reg_dst),
		.rs_data    (ex_rs_data),
		.rt_data    (ex_rt_data),
		.imm_ext    (ex_imm_ext),
		.rt         (ex_rt),
		.rd         (ex_rd),
		.alu_result (alu_result),
		.zero       (zero),
		.dest_reg   (dest_reg)
	);

endmodule

`default_nettype wire

// ==== test/id_ex_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_core_sva (
	input logic        clk,
	input logic        rst,
	input logic        hold,
	input logic [31:0] instr,
	input logic [31:0] rs_data,
	input logic [31:0] rt_data,
	input logic [31:0] alu_result,
	input logic [31:0] store_data,
	input logic        zero,
	input logic [4:0]  dest_reg,
	input logic        reg_write,
	input logic        mem_to_reg,
	input logic        mem_read,
	input logic        mem_write
);

	int failures = 0;

	reset_clears_controls: assert property (@(posedge clk)
		rst |=> !(reg_write || mem_to_reg || mem_read || mem_write))
		else begin
			$error("control outputs not cleared one cycle after reset");
			failures++;
		end

	// a held edge must not move anything the execute side shows
	hold_keeps_outputs: assert property (@(posedge clk)
		(hold && !rst) |=> ($stable(alu_result) && $stable(store_data) && $stable(zero)
			&& $stable(dest_reg)
			&& $stable({reg_write, mem_to_reg, mem_read, mem_write})))
		else begin
			$error("outputs changed across an edge with hold high");
			failures++;
		end

	reg_zero_reads_zero: assert property (@(posedge clk)
		((instr[25:21] != 5'd0) || (rs_data == 32'd0))
		&& ((instr[20:16] != 5'd0) || (rt_data == 32'd0)))
		else begin
			$error("register file returned nonzero data for register 0");
			failures++;
		end

endmodule

bind id_ex_core id_ex_core_sva i_sva (
	.clk        (clk),
	.rst        (rst),
	.hold       (hold),
	.instr      (instr),
	.rs_data    (rs_data),
	.rt_data    (rt_data),
	.alu_result (alu_result),
	.store_data (store_data),
	.zero       (zero),
	.dest_reg   (dest_reg),
	.reg_write  (reg_write),
	.mem_to_reg (mem_to_reg),
	.mem_read   (mem_read),
	.mem_write  (mem_write)
);

`default_nettype wire

// ==== test/tb_id_ex_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_ex_core;
	import mips_pkg::*;

	logic        clk;
	logic        rst;
	logic        hold;
	instr_u      instr;
	logic        wr_en;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic [31:0] alu_result;
	logic [31:0] store_data;
	logic        zero;
	logic [4:0]  dest_reg;
	logic        reg_write;
	logic        mem_to_reg;
	logic        mem_read;
	logic        mem_write;

	// reference copy of the register file contents
	logic [31:0] shadow [32];
	int          word_errors;
	int          reg_errors;
	int          ctrl_errors;

	id_ex_core i_dut (
		.clk        (clk),
		.rst        (rst),
		.hold       (hold),
		.instr      (instr),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.alu_result (alu_result),
		.store_data (store_data),
		.zero       (zero),
		.dest_reg   (dest_reg),
		.reg_write  (reg_write),
		.mem_to_reg (mem_to_reg),
		.mem_read   (mem_read),
		.mem_write  (mem_write)
	);

	always #4 clk = ~clk;

	// last line of defence if the clock ever stops
	initial begin
		#100000;
		$display("Timeout: the simulation ran past its overall time limit");
		$display("Some tests failed");
		$finish;
	end

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			word_errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] expected,
			input logic [4:0] actual);
		if (actual !== expected) begin
			reg_errors++;
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_ctrl(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			ctrl_errors++;
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_controls(input string name, input logic rw, input logic m2r,
			input logic mr, input logic mw);
		check_ctrl({name, " reg_write"}, rw, reg_write);
		check_ctrl({name, " mem_to_reg"}, m2r, mem_to_reg);
		check_ctrl({name, " mem_read"}, mr, mem_read);
		check_ctrl({name, " mem_write"}, mw, mem_write);
	endtask

	// every call starts and ends on a falling edge
	task automatic wait_falls(input int n);
		int  seen;
		time deadline;
		seen = 0;
		deadline = $time + 8 * (n + 1);
		while (seen < n && $time <= deadline) begin
			@(negedge clk);
			seen++;
		end
		if (seen < n) begin
			$display("Timeout: %0d falling clock edges did not arrive in time", n);
			$display("Some tests failed");
			$finish;
		end
	endtask

	function automatic instr_u make_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] funct);
		instr_u w;
		w.r.opcode = OP_RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = 5'd0;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic instr_u make_i(input logic [5:0] opcode, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i.opcode = opcode;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	// what the MIPS ISA says each R-type op produces
	function automatic logic [31:0] expected_rtype(input logic [5:0] funct,
			input logic [31:0] a, input logic [31:0] b);
		case (funct)
			FN_ADD: return a + b;
			FN_SUB: return a - b;
			FN_AND: return a & b;
			FN_OR: return a | b;
			FN_NOR: return ~(a | b);
			FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		wait_falls(1);
		wr_en = 1'b0;
		if (addr != 5'd0) begin
			shadow[addr] = data;
		end
	endtask

	task automatic issue(input instr_u w);
		instr = w;
		wait_falls(1);
	endtask

	task automatic test_reset();
		check_controls("reset", 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_rtype();
		logic [5:0]  functs [6];
		string       names [6];
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] expected;
		functs = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_NOR};
		names = '{"add", "sub", "and", "or", "slt", "nor"};
		for (int k = 1; k <= 8; k++) begin
			write_reg(5'(k), $urandom);
		end
		for (int k = 0; k < 6; k++) begin
			rs = 5'($urandom_range(1, 8));
			rt = 5'($urandom_range(1, 8));
			rd = 5'($urandom_range(1, 31));
			issue(make_r(rs, rt, rd, functs[k]));
			expected = expected_rtype(functs[k], shadow[rs], shadow[rt]);
			check_word({names[k], " alu_result"}, expected, alu_result);
			check_reg({names[k], " dest_reg"}, rd, dest_reg);
			check_controls(names[k], 1'b1, 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic test_itype();
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		logic [31:0] expected;
		string       name;
		for (int k = 0; k < 9; k++) begin
			case (k % 3)
				0: op = OP_ADDI;
				1: op = OP_LW;
				default: op = OP_SW;
			endcase
			rs = 5'($urandom_range(1, 8));
			rt = 5'($urandom_range(1, 8));
			imm = 16'($urandom);
			// odd iterations get a negative immediate
			if (k % 2 == 1) begin
				imm[15] = 1'b1;
			end
			issue(make_i(op, rs, rt, imm));
			expected = shadow[rs] + 32'($signed(imm));
			name = $sformatf("itype %0d", k);
			check_word({name, " alu_result"}, expected, alu_result);
			check_reg({name, " dest_reg"}, rt, dest_reg);
			if (op == OP_ADDI) begin
				check_controls(name, 1'b1, 1'b0, 1'b0, 1'b0);
			end
			else if (op == OP_LW) begin
				check_controls(name, 1'b1, 1'b1, 1'b1, 1'b0);
			end
			else begin
				check_controls(name, 1'b0, 1'b0, 1'b0, 1'b1);
				check_word({name, " store_data"}, shadow[rt], store_data);
			end
		end
	endtask

	task automatic test_hold();
		logic [31:0] first_result;
		logic [31:0] next_result;
		string       name;
		first_result = expected_rtype(FN_ADD, shadow[1], shadow[2]);
		issue(make_r(5'd1, 5'd2, 5'd10, FN_ADD));
		check_word("hold setup alu_result", first_result, alu_result);
		hold = 1'b1;
		for (int k = 0; k < 4; k++) begin
			instr = make_i(OP_LW, 5'($urandom_range(1, 8)), 5'd7, 16'($urandom));
			wait_falls(1);
			name = $sformatf("hold %0d", k);
			check_word({name, " alu_result"}, first_result, alu_result);
			check_reg({name, " dest_reg"}, 5'd10, dest_reg);
			check_controls(name, 1'b1, 1'b0, 1'b0, 1'b0);
		end
		hold = 1'b0;
		next_result = expected_rtype(FN_SUB, shadow[3], shadow[4]);
		issue(make_r(5'd3, 5'd4, 5'd12, FN_SUB));
		check_word("release alu_result", next_result, alu_result);
		check_reg("release dest_reg", 5'd12, dest_reg);
	endtask

	task automatic test_zero_reg();
		write_reg(5'd0, $urandom | 32'h1);
		issue(make_r(5'd0, 5'd3, 5'd11, FN_ADD));
		check_word("r0 as rs", expected_rtype(FN_ADD, shadow[0], shadow[3]), alu_result);
		issue(make_r(5'd3, 5'd0, 5'd11, FN_ADD));
		check_word("r0 as rt", expected_rtype(FN_ADD, shadow[3], shadow[0]), alu_result);
		issue(make_i(6'b111111, 5'd1, 5'd2, 16'h1234));
		check_controls("unknown opcode", 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_zero_flag();
		logic [31:0] value;
		logic [31:0] expected;
		value = $urandom;
		write_reg(5'd4, value);
		write_reg(5'd5, value);
		expected = expected_rtype(FN_SUB, shadow[4], shadow[5]);
		issue(make_r(5'd4, 5'd5, 5'd13, FN_SUB));
		check_word("sub equal alu_result", expected, alu_result);
		check_ctrl("sub equal zero", 1'b1, zero);
		write_reg(5'd5, value ^ 32'h1);
		expected = expected_rtype(FN_SUB, shadow[4], shadow[5]);
		issue(make_r(5'd4, 5'd5, 5'd13, FN_SUB));
		check_word("sub differ alu_result", expected, alu_result);
		check_ctrl("sub differ zero", 1'b0, zero);
	endtask

	initial begin
		int total;
		clk = 1'b0;
		rst = 1'b1;
		hold = 1'b0;
		instr = '0;
		wr_en = 1'b0;
		wr_addr = 5'd0;
		wr_data = 32'd0;
		word_errors = 0;
		reg_errors = 0;
		ctrl_errors = 0;
		for (int k = 0; k < 32; k++) begin
			shadow[k] = 32'd0;
		end
		void'($urandom(32'hc037));
		wait_falls(3);
		rst = 1'b0;

		test_reset();
		test_rtype();
		test_itype();
		test_hold();
		test_zero_reg();
		test_zero_flag();

		total = word_errors + reg_errors + ctrl_errors + i_dut.i_sva.failures;
		$display("Errors: word %0d, reg %0d, ctrl %0d, assertion %0d",
			word_errors, reg_errors, ctrl_errors, i_dut.i_sva.failures);
		if (total == 0) begin
			$display("All tests passed");
		end
		else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== id_ex_core.f ====
common/mips_pkg.sv
decode/control_decoder.sv
decode/reg_file.sv
verilog/id_ex_reg.sv
execute/alu.sv
execute/ex_stage.sv
verilog/id_ex_core.sv
test/id_ex_core_sva.sv
test/tb_id_ex_core.sv

// ==== Makefile ====
# Verilator build for the ID/EX slice testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_id_ex_core
FILELIST  ?= id_ex_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
